// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_apb_subsystem
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
+incdir+hdl
hdl/apb_subsys_pkg.sv
hdl/ahb_apb_bridge.sv
hdl/apb_slot_decode.sv
hdl/irq_wake_ctrl.sv
hdl/apb_subsystem.sv
testbench/tb_apb_subsystem.sv

// ==== hdl/ahb_apb_bridge.sv ====
// AHB-Lite slave to APB bridge, one APB transfer per AHB transfer, no pipelining
// hsize, hburst and hprot are not looked at; every access is a full word
`default_nettype none
`timescale 1ns/1ps

`include "apb_subsys_consts.svh"

module ahb_apb_bridge (
  input  logic                     i_hclk,
  input  logic                     i_arst_n,
  input  apb_subsys_pkg::ahb_req_t i_ahb,
  output apb_subsys_pkg::ahb_rsp_t o_ahb,
  output apb_subsys_pkg::apb_req_t o_apb,
  output logic                     o_psel,
  input  apb_subsys_pkg::apb_rsp_t i_apb
);

  typedef enum logic [2:0] {
    IDLE,   // hready high, waiting for a transfer
    SETUP,  // psel, no penable
    ACCESS, // psel and penable until pready
    ERR1,   // First ERROR cycle, hready low
    ERR2    // Second ERROR cycle, hready high
  } state_e;

  state_e state_q;
  state_e state_d;

  logic               hready_int;
  logic               accept;
  logic [`ADDR_W-1:0] addr_q;  // Address phase capture
  logic               write_q;
  logic [`DATA_W-1:0] wdata_q; // Held from setup on
  logic [`DATA_W-1:0] rdata_q;

  //----------------------------------------------------------------------
  // AHB side
  //----------------------------------------------------------------------
  assign hready_int = (state_q == IDLE) || (state_q == ERR2);
  // NONSEQ or SEQ, bus free and bridge ready
  assign accept = hready_int && i_ahb.hsel && i_ahb.htrans[1] && i_ahb.hready_in;

  assign o_ahb.hready = hready_int;
  assign o_ahb.hresp  = (state_q == ERR1) || (state_q == ERR2);
  assign o_ahb.hrdata = rdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, ERR2: if (accept) state_d = SETUP; else state_d = IDLE;
      SETUP:      state_d = ACCESS;
      ACCESS: begin
        if (i_apb.pready) begin
          state_d = i_apb.pslverr ? ERR1 : IDLE;
        end
      end
      ERR1:       state_d = ERR2;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Transfer payload
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q  <= i_ahb.haddr;
      write_q <= i_ahb.hwrite;
    end
    if (state_q == SETUP) wdata_q <= i_ahb.hwdata; // Data phase of the write
    if (state_q == ACCESS && i_apb.pready && !write_q) begin
      rdata_q <= i_apb.prdata;
    end
  end

  //----------------------------------------------------------------------
  // APB side
  //----------------------------------------------------------------------
  assign o_psel         = (state_q == SETUP) || (state_q == ACCESS);
  assign o_apb.penable  = (state_q == ACCESS);
  assign o_apb.paddr    = addr_q;
  assign o_apb.pwrite   = write_q;
  // Write data straight from AHB in setup, then the held copy
  assign o_apb.pwdata   = (state_q == SETUP) ? i_ahb.hwdata : wdata_q;

  // APB handshake order
  a_penable_needs_psel: assert property (
    @(posedge i_hclk) disable iff (!i_arst_n)
    o_apb.penable |-> o_psel
  ) else $error("penable without psel");

  a_setup_before_access: assert property (
    @(posedge i_hclk) disable iff (!i_arst_n)
    $rose(o_apb.penable) |-> $past(o_psel && !o_apb.penable)
  ) else $error("penable rose without a setup cycle");

endmodule

`default_nettype wire

// ==== hdl/apb_slot_decode.sv ====
// APB slot select and response mux for the nine-slot map from SLOT_BASE
// Unpopulated or out-of-window addresses answer pready and pslverr at once
`default_nettype none
`timescale 1ns/1ps

`include "apb_subsys_consts.svh"

module apb_slot_decode (
  input  apb_subsys_pkg::apb_req_t     i_apb,
  input  logic                         i_psel,
  output apb_subsys_pkg::slot_sel_t    o_sel,
  input  apb_subsys_pkg::apb_rsp_arr_t i_rsp,
  output apb_subsys_pkg::apb_rsp_t     o_rsp
);

  localparam logic [`ADDR_W-1:0]    slot_base = `SLOT_BASE;
  localparam logic [`NUM_SLOTS-1:0] slot_map  = `SLOT_MAP;

  logic [3:0]                slot_idx;  // Address bits 19:16
  logic                      in_window; // Upper bits match the base
  apb_subsys_pkg::slot_sel_t hit;       // Populated slot addressed

  assign slot_idx  = i_apb.paddr[`SLOT_SHIFT+3:`SLOT_SHIFT];
  assign in_window = (i_apb.paddr[`ADDR_W-1:`SLOT_SHIFT+4]
                      == slot_base[`ADDR_W-1:`SLOT_SHIFT+4]);

  always_comb begin
    hit = '0;
    for (int i = 0; i < `NUM_SLOTS; i++) begin
      hit[i] = in_window && slot_map[i] && (slot_idx == 4'(i));
    end
  end

  assign o_sel = i_psel ? hit : '0; // No select outside a transfer

  //----------------------------------------------------------------------
  // Response mux
  //----------------------------------------------------------------------
  always_comb begin
    // Default is the unmapped answer
    o_rsp.prdata  = '0;
    o_rsp.pready  = 1'b1;
    o_rsp.pslverr = 1'b1;
    for (int i = 0; i < `NUM_SLOTS; i++) begin
      if (hit[i]) o_rsp = i_rsp[i];
    end
  end

  // At most one slot driven at a time
  always_comb begin
    a_sel_onehot0: assert ($onehot0(o_sel))
      else $error("more than one APB select high");
  end

endmodule

`default_nettype wire

// ==== hdl/apb_subsys_consts.svh ====
// Widths, APB slot map and interrupt register offsets for the APB subsystem
// Slot index is address bits 19:16, register offsets are the low SLOT_SHIFT bits
`ifndef APB_SUBSYS_CONSTS_SVH
`define APB_SUBSYS_CONSTS_SVH

//----------------------------------------------------------------------
// Bus widths
//----------------------------------------------------------------------
`define ADDR_W 32
`define DATA_W 32

//----------------------------------------------------------------------
// APB slot map
//----------------------------------------------------------------------
`define NUM_SLOTS 9
`define SLOT_BASE 32'h0080_0000 // Slot 0, 64 KiB per slot
`define SLOT_SHIFT 16
// Slots 4 and 7 unpopulated
`define SLOT_MAP 9'b1_0110_1111
`define IRQ_SLOT 6 // Power controller interrupt slave

//----------------------------------------------------------------------
// Interrupt sources and slave registers
//----------------------------------------------------------------------
`define IRQ_W 8
`define GPIO_IRQ_BIT 4
// Offsets inside one slot, SLOT_SHIFT bits wide
`define REG_STATUS 16'h0000
`define REG_CTRL 16'h0004

`endif

// ==== hdl/apb_subsys_pkg.sv ====
// Bus and interrupt types shared by the bridge, decoder and interrupt slave
// APB selects travel apart from apb_req_t, one bit per slot
`default_nettype none

`include "apb_subsys_consts.svh"

package apb_subsys_pkg;

  // AHB-Lite master side, about 69 bits
  typedef struct packed {
    logic              hsel;
    logic [1:0]        htrans;    // NONSEQ 2'b10, SEQ 2'b11
    logic              hwrite;
    logic [`ADDR_W-1:0] haddr;
    logic [`DATA_W-1:0] hwdata;
    logic              hready_in; // Previous transfer done on the bus
  } ahb_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] hrdata;
    logic              hready;
    logic              hresp;     // 0 OKAY, 1 ERROR
  } ahb_rsp_t;

  //----------------------------------------------------------------------
  // APB side
  //----------------------------------------------------------------------
  typedef struct packed {
    logic [`ADDR_W-1:0] paddr;
    logic              pwrite;
    logic [`DATA_W-1:0] pwdata;
    logic              penable;
  } apb_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;   // Only valid with pready
  } apb_rsp_t;

  typedef logic [`NUM_SLOTS-1:0] slot_sel_t;      // One-hot or zero
  typedef apb_rsp_t [`NUM_SLOTS-1:0] apb_rsp_arr_t; // Indexed by slot
  typedef logic [`IRQ_W-1:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== hdl/apb_subsystem.sv ====
// Peripheral bus core: AHB-Lite slave, nine-slot APB map, interrupt wake slave
// Single clock; external slots share o_apb and answer on i_apb_rsp
`default_nettype none
`timescale 1ns/1ps

`include "apb_subsys_consts.svh"

module apb_subsystem (
  input  logic                         i_hclk,
  input  logic                         i_arst_n,
  input  apb_subsys_pkg::ahb_req_t     i_ahb,
  output apb_subsys_pkg::ahb_rsp_t     o_ahb,
  output apb_subsys_pkg::apb_req_t     o_apb,     // Shared by all slots
  output apb_subsys_pkg::slot_sel_t    o_apb_sel,
  input  apb_subsys_pkg::apb_rsp_arr_t i_apb_rsp, // IRQ_SLOT entry unused
  input  apb_subsys_pkg::irq_vec_t     i_irq,
  output logic                         o_wake
);

  logic                         psel;     // Bridge transfer strobe
  apb_subsys_pkg::apb_rsp_t     dec_rsp;  // Selected slot answer
  apb_subsys_pkg::apb_rsp_t     irq_rsp;
  apb_subsys_pkg::apb_rsp_arr_t slot_rsp;

  ahb_apb_bridge u_bridge (
    .i_hclk   (i_hclk),
    .i_arst_n (i_arst_n),
    .i_ahb    (i_ahb),
    .o_ahb    (o_ahb),
    .o_apb    (o_apb),
    .o_psel   (psel),
    .i_apb    (dec_rsp)
  );

  // Internal slave replaces the external entry
  always_comb begin
    slot_rsp            = i_apb_rsp;
    slot_rsp[`IRQ_SLOT] = irq_rsp;
  end

  apb_slot_decode u_decode (
    .i_apb  (o_apb),
    .i_psel (psel),
    .o_sel  (o_apb_sel),
    .i_rsp  (slot_rsp),
    .o_rsp  (dec_rsp)
  );

  irq_wake_ctrl u_irq_wake (
    .i_hclk   (i_hclk),
    .i_arst_n (i_arst_n),
    .i_apb    (o_apb),
    .i_psel   (o_apb_sel[`IRQ_SLOT]),
    .o_rsp    (irq_rsp),
    .i_irq    (i_irq),
    .o_wake   (o_wake)
  );

endmodule

`default_nettype wire

// ==== hdl/irq_wake_ctrl.sv ====
// APB slave with raw interrupt status and the memory isolate bit
// Zero wait states; unknown offsets read zero and ignore writes
`default_nettype none
`timescale 1ns/1ps

`include "apb_subsys_consts.svh"

module irq_wake_ctrl (
  input  logic                     i_hclk,
  input  logic                     i_arst_n,
  input  apb_subsys_pkg::apb_req_t i_apb,
  input  logic                     i_psel,
  output apb_subsys_pkg::apb_rsp_t o_rsp,
  input  apb_subsys_pkg::irq_vec_t i_irq,
  output logic                     o_wake
);

  logic [`SLOT_SHIFT-1:0] reg_off;   // Offset inside the slot
  logic                   ctrl_wr;
  logic                   isolate_q; // Memory isolated, hibernation
  logic                   wake_d;
  logic                   wake_q;

  assign reg_off = i_apb.paddr[`SLOT_SHIFT-1:0];

  //----------------------------------------------------------------------
  // Register access
  //----------------------------------------------------------------------
  // Writes land in the access cycle only
  assign ctrl_wr = i_psel && i_apb.penable && i_apb.pwrite && (reg_off == `REG_CTRL);

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      isolate_q <= 1'b0;
    end else if (ctrl_wr) begin
      isolate_q <= i_apb.pwdata[0]; // Other bits dropped
    end
  end

  always_comb begin
    case (reg_off)
      `REG_STATUS: o_rsp.prdata = {{(`DATA_W-`IRQ_W){1'b0}}, i_irq}; // Raw, unlatched
      `REG_CTRL:   o_rsp.prdata = {{(`DATA_W-1){1'b0}}, isolate_q};
      default:     o_rsp.prdata = '0;
    endcase
  end

  assign o_rsp.pready  = 1'b1; // Never stretches
  assign o_rsp.pslverr = 1'b0;

  //----------------------------------------------------------------------
  // Wake request
  //----------------------------------------------------------------------
  // Sleep: any source wakes. Hibernation: only GPIO wakes
  assign wake_d = ((|i_irq) && !isolate_q) || (isolate_q && i_irq[`GPIO_IRQ_BIT]);

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wake_q <= 1'b0;
    end else begin
      wake_q <= wake_d;
    end
  end

  assign o_wake = wake_q;

  // Setup cycle alone must not touch the isolate bit
  a_no_write_in_setup: assert property (
    @(posedge i_hclk) disable iff (!i_arst_n)
    !i_apb.penable |=> $stable(isolate_q)
  ) else $error("isolate bit changed without penable");

endmodule

`default_nettype wire

// ==== testbench/apb_subsystem_golden.txt ====
// Columns (hex): op, address, write data or i_irq value, expected value
// op 1 write (exp hresp), 2 read (exp hrdata), 3 read (exp hresp), 4 set i_irq (exp o_wake)
1 00800004 a5a50001 0
2 00800004 00000000 a5a50001
1 0081001c 5a5a0102 0
2 0081001c 00000000 5a5a0102
1 00820008 12345678 0
2 00820008 00000000 12345678
1 0083000c deadbeef 0
2 0083000c 00000000 deadbeef
1 00850010 0badf00d 0
2 00850010 00000000 0badf00d
1 00880014 c001d00d 0
2 00880014 00000000 c001d00d
1 00840000 11111111 1
3 00870004 00000000 1
3 00890000 00000000 1
1 008f0008 33333333 1
4 00000000 00000080 1
4 00000000 00000000 0
4 00000000 0000005a 1
2 00860000 00000000 0000005a
1 00860004 ffffffff 0
2 00860004 00000000 00000001
4 00000000 0000002f 0
4 00000000 00000010 1
0 00000000 00000000 00000000

// ==== testbench/tb_apb_subsystem.sv ====
// Replays the golden file through the AHB port, run from the project root
// External slots are 8-word memories with 0 to 3 LFSR-chosen wait states
`default_nettype none
`timescale 1ns/1ps

`include "apb_subsys_consts.svh"

module tb_apb_subsystem;

  localparam int MAX_STEPS = 64;

  logic                         clk;
  logic                         arst_n;
  apb_subsys_pkg::ahb_req_t     ahb_req;
  apb_subsys_pkg::ahb_rsp_t     ahb_rsp;
  apb_subsys_pkg::apb_req_t     apb_req;
  apb_subsys_pkg::slot_sel_t    apb_sel;
  apb_subsys_pkg::apb_rsp_arr_t apb_rsp;
  apb_subsys_pkg::irq_vec_t     irq;
  logic                         wake;

  logic [31:0] golden [0:4*MAX_STEPS-1]; // Four words per step
  logic [31:0] slot_mem [0:`NUM_SLOTS-1][0:7];
  logic [31:0] lfsr_q;
  int          cur_slot;    // Slot of the access in flight
  logic [2:0]  cur_word;
  int          errors = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0; // Zero until the golden file is counted

  apb_subsystem dut (
    .i_hclk    (clk),
    .i_arst_n  (arst_n),
    .i_ahb     (ahb_req),
    .o_ahb     (ahb_rsp),
    .o_apb     (apb_req),
    .o_apb_sel (apb_sel),
    .i_apb_rsp (apb_rsp),
    .i_irq     (irq),
    .o_wake    (wake)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: the bus hung, no response after %0d cycles", cycle_cnt);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
    end
  end

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------
  // Galois step, taps x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
  endfunction

  function automatic logic take_bit();
    take_bit = lfsr_q[0];
    lfsr_q   = lfsr_next(lfsr_q);
  endfunction

  function automatic int sel_index(input apb_subsys_pkg::slot_sel_t sel);
    sel_index = -1;
    for (int i = 0; i < `NUM_SLOTS; i++) begin
      if (sel[i]) sel_index = i;
    end
  endfunction

  // Addressed slot's bit for a good access, none for a failing one
  function automatic apb_subsys_pkg::slot_sel_t expected_sel(input logic [31:0] addr,
                                                             input logic fails);
    expected_sel = '0;
    if (!fails) begin
      expected_sel = `NUM_SLOTS'(1) << addr[19:16];
    end
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // One AHB transfer, entered and left 1 ns after a rising edge
  task automatic ahb_transfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic resp, output int cycles, output logic err_low,
                              output apb_subsys_pkg::slot_sel_t sel_or);
    cycles  = 0;
    err_low = 1'b0;
    sel_or  = '0;
    ahb_req.hsel   = 1'b1;
    ahb_req.htrans = 2'b10; // NONSEQ
    ahb_req.hwrite = wr;
    ahb_req.haddr  = addr;
    @(posedge clk);         // Address phase taken
    #1;
    ahb_req.hsel   = 1'b0;
    ahb_req.htrans = 2'b00;
    ahb_req.hwdata = wdata; // Data phase
    do begin
      @(negedge clk);
      cycles++;
      sel_or = sel_or | apb_sel;
      if (!ahb_rsp.hready && ahb_rsp.hresp) err_low = 1'b1; // First ERROR cycle
    end while (!ahb_rsp.hready);
    rdata = ahb_rsp.hrdata;
    resp  = ahb_rsp.hresp;
    @(posedge clk);
    #1;
  endtask

  //----------------------------------------------------------------------
  // External slot memories
  //----------------------------------------------------------------------
  initial begin : slot_models
    int         s;
    logic       ready_nx; // pready for the next cycle
    logic [1:0] waits;
    lfsr_q   = 32'h1585685d;
    cur_slot = -1;
    cur_word = '0;
    waits    = '0;
    apb_rsp  = '0;
    for (int i = 0; i < `NUM_SLOTS; i++) begin
      for (int w = 0; w < 8; w++) begin
        slot_mem[i][w] = {16'hf11f, 8'(i), 8'(w)};
      end
    end
    forever begin
      @(negedge clk);
      ready_nx = 1'b0;
      s = sel_index(apb_sel);
      if (s >= 0 && s != `IRQ_SLOT) begin
        if (!apb_req.penable) begin
          cur_slot = s; // Setup cycle, draw wait states
          cur_word = apb_req.paddr[4:2];
          waits[0] = take_bit();
          waits[1] = take_bit();
          ready_nx = (waits == 2'd0);
        end else if (apb_rsp[s].pready) begin
          if (apb_req.pwrite) slot_mem[s][cur_word] = apb_req.pwdata;
        end else begin
          waits    = waits - 2'd1;
          ready_nx = (waits == 2'd0);
        end
      end
      @(posedge clk);
      #1;
      apb_rsp = '0;
      if (cur_slot >= 0) begin
        apb_rsp[cur_slot].prdata = slot_mem[cur_slot][cur_word];
        apb_rsp[cur_slot].pready = ready_nx;
      end
    end
  end

  //----------------------------------------------------------------------
  // Golden replay
  //----------------------------------------------------------------------
  initial begin
    int                        steps;
    int                        cycles;
    logic [31:0]               op;
    logic [31:0]               addr;
    logic [31:0]               data;
    logic [31:0]               exp;
    logic [31:0]               rdata;
    logic                      resp;
    logic                      err_low;
    apb_subsys_pkg::slot_sel_t sel_or;
    string                     name;
    arst_n = 1'b0;
    ahb_req = '0;
    ahb_req.hready_in = 1'b1; // Single master, bus always free
    irq = '0;
    $readmemh("testbench/apb_subsystem_golden.txt", golden);
    steps = 0;
    while (steps < MAX_STEPS && golden[4*steps] != 32'd0) steps++; // Op 0 ends the list
    cycle_limit = steps * 40;
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check("reset hready", 32'(1), 32'(ahb_rsp.hready));
    check("reset hresp", 32'(0), 32'(ahb_rsp.hresp));
    check("reset selects", 32'(0), 32'(apb_sel));
    check("reset penable", 32'(0), 32'(apb_req.penable));
    check("reset wake", 32'(0), 32'(wake));
    @(posedge clk);
    #1;
    for (int i = 0; i < steps; i++) begin
      op   = golden[4*i];
      addr = golden[4*i+1];
      data = golden[4*i+2];
      exp  = golden[4*i+3];
      name = $sformatf("step %0d op %0h addr %h", i, op, addr);
      if (op == 32'd4) begin
        irq = data[`IRQ_W-1:0];
        @(posedge clk);     // Wake register samples
        @(negedge clk);
        check({name, " wake"}, exp, 32'(wake));
        @(posedge clk);
        #1;
      end else begin
        ahb_transfer(op == 32'd1, addr, data, rdata, resp, cycles, err_low, sel_or);
        if (op == 32'd2) begin
          check({name, " hresp"}, 32'(0), 32'(resp));
          check({name, " hrdata"}, exp, rdata);
        end else begin
          check({name, " hresp"}, exp, 32'(resp));
        end
        check({name, " select"}, 32'(expected_sel(addr, op != 32'd2 && exp != 32'd0)),
              32'(sel_or));
        if (resp) begin
          // Setup, access, then two ERROR cycles
          check({name, " error first cycle"}, 32'(1), 32'(err_low));
          check({name, " error latency"}, 32'(4), 32'(cycles));
        end else if (addr[19:16] == 4'(`IRQ_SLOT)) begin
          check({name, " irq slave latency"}, 32'(3), 32'(cycles));
        end
      end
    end
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
